/* design/ecc_params.svh */
`ifndef ECC_PARAMS_SVH
`define ECC_PARAMS_SVH

// data and check field widths.
`define ECC_DATA_W 81
`define ECC_CHK_W  8

// stored codeword, check bits above data.
`define ECC_CW_W   89

// storage geometry.
`define ECC_ADDR_W 6
`define ECC_DEPTH  64

// error counter width.
`define ECC_CNT_W  16

`endif

/* design/ecc_pkg.sv */
`default_nettype none

`include "ecc_params.svh"

package ecc_pkg;

    // user data word.
    typedef logic [`ECC_DATA_W-1:0] data_t;

    // secded check field.
    typedef logic [`ECC_CHK_W-1:0] chk_t;

    // check bits sit above the data bits.
    typedef logic [`ECC_CW_W-1:0] cw_t;

    // word address into the array.
    typedef logic [`ECC_ADDR_W-1:0] addr_t;

    // saturating error counter.
    typedef logic [`ECC_CNT_W-1:0] cnt_t;

endpackage

`default_nettype wire

/* design/ecc_81_codec.sv */
`default_nettype none

`include "ecc_params.svh"

module ecc_81_codec import ecc_pkg::*; (
    input  data_t data_in,
    input  chk_t  parity_in,
    input  logic  bypass,
    output data_t data_out,
    output chk_t  parity_out,
    output logic  sbit_err,
    output logic  dbit_err
);

    chk_t       syndrome;
    data_t      mask;
    logic [1:0] error;

    // the eight parity equations of the 81-bit code.
    function automatic chk_t ecc_encode(input data_t d);
        chk_t p;
        p[0] = d[0]  ^ d[1]  ^ d[3]  ^ d[4]  ^ d[6]  ^ d[8]
             ^ d[10] ^ d[11] ^ d[13] ^ d[15] ^ d[17] ^ d[19]
             ^ d[21] ^ d[23] ^ d[25] ^ d[26] ^ d[28] ^ d[30]
             ^ d[32] ^ d[34] ^ d[36] ^ d[38] ^ d[40] ^ d[42]
             ^ d[44] ^ d[46] ^ d[48] ^ d[50] ^ d[52] ^ d[54]
             ^ d[56] ^ d[57] ^ d[59] ^ d[61] ^ d[63] ^ d[65]
             ^ d[67] ^ d[69] ^ d[71] ^ d[73] ^ d[75] ^ d[77]
             ^ d[79];
        p[1] = d[0]  ^ d[2]  ^ d[3]  ^ d[5]  ^ d[6]  ^ d[9]
             ^ d[10] ^ d[12] ^ d[13] ^ d[16] ^ d[17] ^ d[20]
             ^ d[21] ^ d[24] ^ d[25] ^ d[27] ^ d[28] ^ d[31]
             ^ d[32] ^ d[35] ^ d[36] ^ d[39] ^ d[40] ^ d[43]
             ^ d[44] ^ d[47] ^ d[48] ^ d[51] ^ d[52] ^ d[55]
             ^ d[56] ^ d[58] ^ d[59] ^ d[62] ^ d[63] ^ d[66]
             ^ d[67] ^ d[70] ^ d[71] ^ d[74] ^ d[75] ^ d[78]
             ^ d[79];
        p[2] = d[1]  ^ d[2]  ^ d[3]  ^ d[7]  ^ d[8]  ^ d[9]
             ^ d[10] ^ d[14] ^ d[15] ^ d[16] ^ d[17] ^ d[22]
             ^ d[23] ^ d[24] ^ d[25] ^ d[29] ^ d[30] ^ d[31]
             ^ d[32] ^ d[37] ^ d[38] ^ d[39] ^ d[40] ^ d[45]
             ^ d[46] ^ d[47] ^ d[48] ^ d[53] ^ d[54] ^ d[55]
             ^ d[56] ^ d[60] ^ d[61] ^ d[62] ^ d[63] ^ d[68]
             ^ d[69] ^ d[70] ^ d[71] ^ d[76] ^ d[77] ^ d[78]
             ^ d[79];
        p[3] = (^d[10:4]) ^ (^d[25:18]) ^ (^d[40:33])
             ^ (^d[56:49]) ^ (^d[71:64]) ^ d[80];
        p[4] = (^d[25:11]) ^ (^d[56:41]) ^ (^d[80:72]);
        p[5] = ^d[56:26];
        p[6] = ^d[80:57];
        // overall bit, keeps every data column odd weight.
        p[7] = d[0]  ^ d[1]  ^ d[2]  ^ d[4]  ^ d[5]  ^ d[7]
             ^ d[10] ^ d[11] ^ d[12] ^ d[14] ^ d[17] ^ d[18]
             ^ d[21] ^ d[23] ^ d[24] ^ d[26] ^ d[27] ^ d[29]
             ^ d[32] ^ d[33] ^ d[36] ^ d[38] ^ d[39] ^ d[41]
             ^ d[44] ^ d[46] ^ d[47] ^ d[50] ^ d[51] ^ d[53]
             ^ d[56] ^ d[57] ^ d[58] ^ d[60] ^ d[63] ^ d[64]
             ^ d[67] ^ d[69] ^ d[70] ^ d[72] ^ d[75] ^ d[77]
             ^ d[78];
        return p;
    endfunction

    // syndrome left by a flip of data bit idx.
    function automatic chk_t col_code(input int idx);
        data_t onehot;
        onehot      = '0;
        onehot[idx] = 1'b1;
        return ecc_encode(onehot);
    endfunction

    assign parity_out = ecc_encode(data_in);
    assign syndrome   = parity_in ^ parity_out;

    // error class: 01 single, 10 double or worse.
    always_comb begin
        mask  = '0;
        error = 2'b00;
        if (syndrome != '0) begin
            error = 2'b10;
            // a lone check bit flipped, data is fine.
            if ($onehot(syndrome)) begin
                error = 2'b01;
            end
            for (int i = 0; i < `ECC_DATA_W; i++) begin
                if (syndrome == col_code(i)) begin
                    mask[i] = 1'b1;
                    error   = 2'b01;
                end
            end
        end
    end

    assign data_out = bypass ? data_in : data_in ^ mask;
    assign sbit_err = bypass ? 1'b0 : error[0];
    assign dbit_err = bypass ? 1'b0 : error[1];

endmodule

`default_nettype wire

/* design/ecc_mem_array.sv */
`default_nettype none

`include "ecc_params.svh"

module ecc_mem_array import ecc_pkg::*; (
    input  logic  clk,
    input  logic  wr_en,
    input  addr_t wr_addr,
    input  cw_t   wr_cw,
    input  logic  rd_en,
    input  addr_t rd_addr,
    output cw_t   rd_cw
);

    cw_t mem [`ECC_DEPTH];

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_cw;
        end
    end

    // same-edge collision returns the old word.
    always_ff @(posedge clk) begin
        if (rd_en) begin
            rd_cw <= mem[rd_addr];
        end
    end

endmodule

`default_nettype wire

/* design/ecc_read_pipe.sv */
`default_nettype none

`include "ecc_params.svh"

module ecc_read_pipe import ecc_pkg::*; (
    input  logic  clk,
    input  logic  rst_n,
    input  logic  rd_en,
    input  addr_t rd_addr,
    input  logic  bypass,
    input  cw_t   rd_cw,
    output logic  rd_valid,
    output data_t rd_data,
    output logic  sbit_err,
    output logic  dbit_err,
    output addr_t err_addr
);

    logic  s1_valid;
    addr_t s1_addr;
    logic  s1_bypass;

    data_t cw_data;
    chk_t  cw_chk;
    data_t dec_data;
    logic  dec_sbit;
    logic  dec_dbit;

    // stage one lines up with the array read register.
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            s1_valid <= 1'b0;
        end else begin
            s1_valid <= rd_en;
        end
    end

    always_ff @(posedge clk) begin
        if (rd_en) begin
            s1_addr   <= rd_addr;
            s1_bypass <= bypass;
        end
    end

    assign cw_data = rd_cw[`ECC_DATA_W-1:0];
    assign cw_chk  = rd_cw[`ECC_CW_W-1:`ECC_DATA_W];

    ecc_81_codec u_dec (
        .data_in    (cw_data),
        .parity_in  (cw_chk),
        .bypass     (s1_bypass),
        .data_out   (dec_data),
        .parity_out (),
        .sbit_err   (dec_sbit),
        .dbit_err   (dec_dbit)
    );

    // stage two.
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rd_valid <= 1'b0;
            sbit_err <= 1'b0;
            dbit_err <= 1'b0;
        end else begin
            rd_valid <= s1_valid;
            sbit_err <= s1_valid & dec_sbit;
            dbit_err <= s1_valid & dec_dbit;
        end
    end

    always_ff @(posedge clk) begin
        if (s1_valid) begin
            rd_data  <= dec_data;
            err_addr <= s1_addr;
        end
    end

endmodule

`default_nettype wire

/* design/ecc_err_log.sv */
`default_nettype none

`include "ecc_params.svh"

module ecc_err_log import ecc_pkg::*; (
    input  logic  clk,
    input  logic  rst_n,
    input  logic  rd_valid,
    input  logic  sbit_err,
    input  logic  dbit_err,
    input  addr_t err_addr,
    output cnt_t  sbit_count,
    output cnt_t  dbit_count,
    output addr_t last_err_addr
);

    logic sbit_hit;
    logic dbit_hit;

    assign sbit_hit = rd_valid & sbit_err;
    assign dbit_hit = rd_valid & dbit_err;

    // counters hold at all ones.
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            sbit_count <= '0;
            dbit_count <= '0;
        end else begin
            if (sbit_hit && (sbit_count != '1)) begin
                sbit_count <= sbit_count + 1'b1;
            end
            if (dbit_hit && (dbit_count != '1)) begin
                dbit_count <= dbit_count + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            last_err_addr <= '0;
        end else if (sbit_hit || dbit_hit) begin
            last_err_addr <= err_addr;
        end
    end

endmodule

`default_nettype wire

/* design/ecc_mem_top.sv */
`default_nettype none

`include "ecc_params.svh"

module ecc_mem_top import ecc_pkg::*; (
    input  logic  clk,
    input  logic  rst_n,
    input  logic  wr_en,
    input  addr_t wr_addr,
    input  data_t wr_data,
    input  cw_t   inj_mask,
    input  logic  rd_en,
    input  addr_t rd_addr,
    input  logic  bypass,
    output logic  rd_valid,
    output data_t rd_data,
    output logic  sbit_err,
    output logic  dbit_err,
    output cnt_t  sbit_count,
    output cnt_t  dbit_count,
    output addr_t last_err_addr
);

    chk_t  wr_chk;
    cw_t   wr_cw;
    cw_t   rd_cw;
    addr_t err_addr;

    // encoder only, decode outputs stay open.
    ecc_81_codec u_wr_enc (
        .data_in    (wr_data),
        .parity_in  ('0),
        .bypass     (1'b0),
        .data_out   (),
        .parity_out (wr_chk),
        .sbit_err   (),
        .dbit_err   ()
    );

    // injection flips chosen codeword bits on the way in.
    assign wr_cw = {wr_chk, wr_data} ^ inj_mask;

    ecc_mem_array u_array (
        .clk     (clk),
        .wr_en   (wr_en),
        .wr_addr (wr_addr),
        .wr_cw   (wr_cw),
        .rd_en   (rd_en),
        .rd_addr (rd_addr),
        .rd_cw   (rd_cw)
    );

    ecc_read_pipe u_rd_pipe (
        .clk      (clk),
        .rst_n    (rst_n),
        .rd_en    (rd_en),
        .rd_addr  (rd_addr),
        .bypass   (bypass),
        .rd_cw    (rd_cw),
        .rd_valid (rd_valid),
        .rd_data  (rd_data),
        .sbit_err (sbit_err),
        .dbit_err (dbit_err),
        .err_addr (err_addr)
    );

    ecc_err_log u_err_log (
        .clk           (clk),
        .rst_n         (rst_n),
        .rd_valid      (rd_valid),
        .sbit_err      (sbit_err),
        .dbit_err      (dbit_err),
        .err_addr      (err_addr),
        .sbit_count    (sbit_count),
        .dbit_count    (dbit_count),
        .last_err_addr (last_err_addr)
    );

endmodule

`default_nettype wire

/* verification/ecc_mem_tb.sv */
`default_nettype none

`include "ecc_params.svh"

module ecc_mem_tb import ecc_pkg::*; ();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int NUM_TESTS       = 16;
    localparam int WATCHDOG_CYCLES = NUM_TESTS * 10 + 100;

    logic  clk;
    logic  rst_n;
    logic  wr_en;
    addr_t wr_addr;
    data_t wr_data;
    cw_t   inj_mask;
    logic  rd_en;
    addr_t rd_addr;
    logic  bypass;
    logic  rd_valid;
    data_t rd_data;
    logic  sbit_err;
    logic  dbit_err;
    cnt_t  sbit_count;
    cnt_t  dbit_count;
    addr_t last_err_addr;

    // stimulus table and expected results.
    // expected class is 0 for clean, 1 for single and 2 for double.
    addr_t tab_addr  [NUM_TESTS];
    data_t tab_data  [NUM_TESTS];
    cw_t   tab_mask  [NUM_TESTS];
    logic  tab_byp   [NUM_TESTS];
    data_t exp_data  [NUM_TESTS];
    int    exp_class [NUM_TESTS];
    int    n_entries;

    int pending [$];
    int err_count;
    int tests_run;
    int tests_failed;

    ecc_mem_top DUT (
        .clk           (clk),
        .rst_n         (rst_n),
        .wr_en         (wr_en),
        .wr_addr       (wr_addr),
        .wr_data       (wr_data),
        .inj_mask      (inj_mask),
        .rd_en         (rd_en),
        .rd_addr       (rd_addr),
        .bypass        (bypass),
        .rd_valid      (rd_valid),
        .rd_data       (rd_data),
        .sbit_err      (sbit_err),
        .dbit_err      (dbit_err),
        .sbit_count    (sbit_count),
        .dbit_count    (dbit_count),
        .last_err_addr (last_err_addr)
    );

    always #2 clk = ~clk;

    // hamming column of data bit idx.
    // positions skip powers of two.
    function automatic chk_t column_of(input int idx);
        int   pos;
        int   seen;
        chk_t col;
        pos  = 2;
        seen = -1;
        while (seen < idx) begin
            pos++;
            if ((pos & (pos - 1)) != 0) begin
                seen++;
            end
        end
        col[6:0] = pos[6:0];
        // top bit makes the column odd weight.
        col[7]   = ~(^pos[6:0]);
        return col;
    endfunction

    function automatic chk_t check_bits_of(input data_t d);
        chk_t p;
        p = '0;
        for (int i = 0; i < `ECC_DATA_W; i++) begin
            if (d[i]) begin
                p = p ^ column_of(i);
            end
        end
        return p;
    endfunction

    function automatic cw_t bit_mask(input int b);
        cw_t m;
        m    = '0;
        m[b] = 1'b1;
        return m;
    endfunction

    function automatic data_t rand_data();
        logic [95:0] r;
        r = {$urandom, $urandom, $urandom};
        return r[`ECC_DATA_W-1:0];
    endfunction

    // expected read result under the secded decode.
    task automatic predict(input data_t d, input cw_t m, input logic b,
                           output data_t ed, output int cls);
        data_t md;
        chk_t  mc;
        chk_t  syn;
        data_t fix;
        md  = m[`ECC_DATA_W-1:0];
        mc  = m[`ECC_CW_W-1:`ECC_DATA_W];
        syn = check_bits_of(md) ^ mc;
        fix = '0;
        cls = 0;
        if (syn != '0) begin
            cls = 2;
            for (int i = 0; i < `ECC_DATA_W; i++) begin
                if (syn == column_of(i)) begin
                    fix[i] = 1'b1;
                    cls    = 1;
                end
            end
            if ($countones(syn) == 1) begin
                cls = 1;
            end
        end
        if (b) begin
            ed  = d ^ md;
            cls = 0;
        end else begin
            ed = d ^ md ^ fix;
        end
    endtask

    task automatic add_entry(input addr_t a, input data_t d, input cw_t m, input logic b);
        tab_addr[n_entries] = a;
        tab_data[n_entries] = d;
        tab_mask[n_entries] = m;
        tab_byp[n_entries]  = b;
        predict(d, m, b, exp_data[n_entries], exp_class[n_entries]);
        n_entries++;
    endtask

    task automatic compare(input string name, input logic [127:0] actual,
                           input logic [127:0] expected);
        if (actual !== expected) begin
            $display("CHECK FAILED at %0t: %s got %h expected %h",
                     $time, name, actual, expected);
            err_count++;
        end
    endtask

    // read results are sampled away from the driving edge.
    always @(negedge clk) begin
        if (rst_n && rd_valid) begin : check_read
            int idx;
            int errs_before;
            if (pending.size() == 0) begin
                $display("error: rd_valid at %0t with no read outstanding", $time);
                err_count++;
            end else begin
                idx         = pending.pop_front();
                errs_before = err_count;
                compare("rd_data", rd_data, exp_data[idx]);
                compare("sbit_err", sbit_err, exp_class[idx] == 1);
                compare("dbit_err", dbit_err, exp_class[idx] == 2);
                tests_run++;
                if (err_count != errs_before) begin
                    tests_failed++;
                    $display("test %0d addr %0d: failed", idx, tab_addr[idx]);
                end else begin
                    $display("test %0d addr %0d: passed", idx, tab_addr[idx]);
                end
            end
        end
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("timeout: run did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("STATUS: FAIL");
        $finish;
    end

    initial begin
        int    wait_cycles;
        int    errs_before;
        int    exp_s;
        int    exp_d;
        addr_t exp_last;
        $timeformat(-9, 0, " ns", 0);
        clk          = 1'b0;
        rst_n        = 1'b0;
        wr_en        = 1'b0;
        wr_addr      = '0;
        wr_data      = '0;
        inj_mask     = '0;
        rd_en        = 1'b0;
        rd_addr      = '0;
        bypass       = 1'b0;
        n_entries    = 0;
        err_count    = 0;
        tests_run    = 0;
        tests_failed = 0;
        void'($urandom(94));

        add_entry(6'd0,  rand_data(), '0, 1'b0);
        add_entry(6'd1,  '1, '0, 1'b0);
        add_entry(6'd2,  rand_data(), bit_mask(0), 1'b0);
        add_entry(6'd3,  rand_data(), bit_mask(80), 1'b0);
        add_entry(6'd4,  rand_data(), bit_mask(41), 1'b0);
        add_entry(6'd5,  rand_data(), bit_mask(81), 1'b0);
        add_entry(6'd6,  rand_data(), bit_mask(88), 1'b0);
        add_entry(6'd7,  rand_data(), bit_mask(3) | bit_mask(77), 1'b0);
        add_entry(6'd8,  rand_data(), bit_mask(10) | bit_mask(84), 1'b0);
        add_entry(6'd9,  '0, bit_mask(82) | bit_mask(83), 1'b0);
        add_entry(6'd10, rand_data(), bit_mask(5), 1'b1);
        add_entry(6'd11, rand_data(), bit_mask(20) | bit_mask(60), 1'b1);
        add_entry(6'd63, rand_data(), '0, 1'b1);
        add_entry(6'd12, rand_data(), bit_mask(60), 1'b0);
        add_entry(6'd13, rand_data(), bit_mask(0) | bit_mask(1), 1'b0);
        add_entry(6'd14, rand_data(), bit_mask(86), 1'b0);

        repeat (4) @(posedge clk);
        rst_n <= 1'b1;

        // even groups of four read back to back.
        for (int g = 0; g < NUM_TESTS; g += 4) begin
            for (int i = g; i < g + 4; i++) begin
                @(posedge clk);
                wr_en    <= 1'b1;
                wr_addr  <= tab_addr[i];
                wr_data  <= tab_data[i];
                inj_mask <= tab_mask[i];
            end
            @(posedge clk);
            wr_en    <= 1'b0;
            inj_mask <= '0;
            for (int i = g; i < g + 4; i++) begin
                @(posedge clk);
                rd_en   <= 1'b1;
                rd_addr <= tab_addr[i];
                bypass  <= tab_byp[i];
                pending.push_back(i);
                if ((g / 4) % 2 == 1) begin
                    @(posedge clk);
                    rd_en <= 1'b0;
                end
            end
            @(posedge clk);
            rd_en  <= 1'b0;
            bypass <= 1'b0;
        end

        wait_cycles = 0;
        while (pending.size() != 0 && wait_cycles < 20) begin
            @(negedge clk);
            wait_cycles++;
        end
        if (pending.size() != 0) begin
            $display("error: %0d read(s) never produced rd_valid", pending.size());
            err_count++;
        end
        repeat (2) @(negedge clk);

        exp_s    = 0;
        exp_d    = 0;
        exp_last = '0;
        for (int i = 0; i < NUM_TESTS; i++) begin
            if (exp_class[i] == 1) begin
                exp_s++;
            end
            if (exp_class[i] == 2) begin
                exp_d++;
            end
            if (exp_class[i] != 0) begin
                exp_last = tab_addr[i];
            end
        end
        errs_before = err_count;
        compare("sbit_count", sbit_count, exp_s);
        compare("dbit_count", dbit_count, exp_d);
        compare("last_err_addr", last_err_addr, exp_last);
        tests_run++;
        if (err_count != errs_before) begin
            tests_failed++;
            $display("test error log: failed");
        end else begin
            $display("test error log: passed");
        end

        $display("tests run %0d, passed %0d, failed %0d, errors %0d",
                 tests_run, tests_run - tests_failed, tests_failed, err_count);
        if (err_count == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* filelist.f */
+incdir+design
design/ecc_pkg.sv
design/ecc_81_codec.sv
design/ecc_mem_array.sv
design/ecc_read_pipe.sv
design/ecc_err_log.sv
design/ecc_mem_top.sv
verification/ecc_mem_tb.sv
